// ==== csa_search.f ====
+incdir+test
design/csa_search_pkg.sv
design/slot_entry.sv
design/key_schedule.sv
design/cipher_pipe.sv
design/slot_delay.sv
design/match_decide.sv
design/csa_search_top.sv
test/csa_search_tb.sv

// ==== design/cipher_pipe.sv ====
`timescale 1ns/1ns

module cipher_pipe (
	input logic clk,
	input logic rst_n,

	input logic [csa_search_pkg::WORD_W-1:0] key_i,
	output logic [csa_search_pkg::WORD_W-1:0] word_o
);

	logic [csa_search_pkg::WORD_W-1:0] stage_q [csa_search_pkg::ROUNDS];

	// add rotated constant, then fold the sum onto itself
	function automatic logic [csa_search_pkg::WORD_W-1:0] round_f(
		input logic [csa_search_pkg::WORD_W-1:0] x,
		input int r
	);
		logic [csa_search_pkg::WORD_W-1:0] rc;
		logic [csa_search_pkg::WORD_W-1:0] s;
		logic [csa_search_pkg::WORD_W-1:0] s_rot;

		rc = (csa_search_pkg::CIPHER_CONST << r) |
			(csa_search_pkg::CIPHER_CONST >> (csa_search_pkg::WORD_W - r));
		s = x + rc;
		s_rot = {s[csa_search_pkg::WORD_W-1-csa_search_pkg::ROT_MIX:0],
			s[csa_search_pkg::WORD_W-1:csa_search_pkg::WORD_W-csa_search_pkg::ROT_MIX]};
		return s ^ s_rot;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < csa_search_pkg::ROUNDS; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= round_f(key_i, 0);
			for (int i = 1; i < csa_search_pkg::ROUNDS; i++) begin
				stage_q[i] <= round_f(stage_q[i-1], i); // round i in stage i
			end
		end
	end

	assign word_o = stage_q[csa_search_pkg::ROUNDS-1];

endmodule

// ==== design/csa_search_pkg.sv ====
package csa_search_pkg;

	// word widths
	localparam int WORD_W = 64; // cipher word, key, seed, mask, value
	localparam int BLOCK_W = 32;
	localparam int COUNT_W = 16;

	// ring geometry
	localparam int ROUNDS = 8;
	// entry reg + key reg + cipher stages
	localparam int RING_DEPTH = ROUNDS + 2;

	// fixed cipher constant, rotated per round
	localparam logic [WORD_W-1:0] CIPHER_CONST = 64'hE613DB6DC11C4524;
	localparam int ROT_MIX = 13; // self-xor rotate in each round

endpackage

// ==== design/csa_search_top.sv ====
`timescale 1ns/1ns

module csa_search_top (
	input logic clk,
	input logic rst_n,

	input logic fifo_ready_i,
	output logic fifo_ren_o,
	input logic [csa_search_pkg::BLOCK_W-1:0] job_block_i,
	input logic [csa_search_pkg::WORD_W-1:0] job_seed_i,
	input logic [csa_search_pkg::COUNT_W-1:0] job_count_i,

	input logic [csa_search_pkg::WORD_W-1:0] mask_i,
	input logic [csa_search_pkg::WORD_W-1:0] value_i,
	input logic out_full_i,

	output logic result_valid_o,
	output logic [csa_search_pkg::BLOCK_W-1:0] result_block_o,
	output logic [csa_search_pkg::WORD_W-1:0] result_seed_o,
	output logic [csa_search_pkg::COUNT_W-1:0] result_count_o,
	output logic [csa_search_pkg::WORD_W-1:0] result_word_o,
	output logic result_last_o
);

	// entry slot
	logic en_valid;
	logic [csa_search_pkg::BLOCK_W-1:0] en_block;
	logic [csa_search_pkg::WORD_W-1:0] en_seed;
	logic [csa_search_pkg::COUNT_W-1:0] en_left;
	logic [csa_search_pkg::COUNT_W-1:0] en_total;
	logic [csa_search_pkg::WORD_W-1:0] en_prev;
	logic en_first;

	// key stage slot
	logic [csa_search_pkg::WORD_W-1:0] key;
	logic ks_valid;
	logic [csa_search_pkg::BLOCK_W-1:0] ks_block;
	logic [csa_search_pkg::WORD_W-1:0] ks_seed;
	logic [csa_search_pkg::COUNT_W-1:0] ks_left;
	logic [csa_search_pkg::COUNT_W-1:0] ks_total;
	logic ks_first;

	logic [csa_search_pkg::WORD_W-1:0] word;

	// slot aligned with word
	logic sl_valid;
	logic [csa_search_pkg::BLOCK_W-1:0] sl_block;
	logic [csa_search_pkg::WORD_W-1:0] sl_seed;
	logic [csa_search_pkg::COUNT_W-1:0] sl_left;
	logic [csa_search_pkg::COUNT_W-1:0] sl_total;
	logic [csa_search_pkg::WORD_W-1:0] sl_prev;
	logic sl_first;

	// recirculation path
	logic rc_valid;
	logic [csa_search_pkg::BLOCK_W-1:0] rc_block;
	logic [csa_search_pkg::WORD_W-1:0] rc_seed;
	logic [csa_search_pkg::COUNT_W-1:0] rc_left;
	logic [csa_search_pkg::COUNT_W-1:0] rc_total;
	logic [csa_search_pkg::WORD_W-1:0] rc_prev;
	logic rc_first;

	slot_entry u_entry (
		.clk(clk),
		.rst_n(rst_n),
		.fifo_ready_i(fifo_ready_i),
		.fifo_ren_o(fifo_ren_o),
		.job_block_i(job_block_i),
		.job_seed_i(job_seed_i),
		.job_count_i(job_count_i),
		.rc_valid_i(rc_valid),
		.rc_block_i(rc_block),
		.rc_seed_i(rc_seed),
		.rc_left_i(rc_left),
		.rc_total_i(rc_total),
		.rc_prev_i(rc_prev),
		.rc_first_i(rc_first),
		.en_valid_o(en_valid),
		.en_block_o(en_block),
		.en_seed_o(en_seed),
		.en_left_o(en_left),
		.en_total_o(en_total),
		.en_prev_o(en_prev),
		.en_first_o(en_first)
	);

	key_schedule u_key (
		.clk(clk),
		.rst_n(rst_n),
		.valid_i(en_valid),
		.block_i(en_block),
		.seed_i(en_seed),
		.left_i(en_left),
		.total_i(en_total),
		.prev_i(en_prev),
		.first_i(en_first),
		.key_o(key),
		.ks_valid_o(ks_valid),
		.ks_block_o(ks_block),
		.ks_seed_o(ks_seed),
		.ks_left_o(ks_left),
		.ks_total_o(ks_total),
		.ks_first_o(ks_first)
	);

	cipher_pipe u_cipher (
		.clk(clk),
		.rst_n(rst_n),
		.key_i(key),
		.word_o(word)
	);

	slot_delay #(
		.DEPTH(csa_search_pkg::ROUNDS)
	) u_delay (
		.clk(clk),
		.rst_n(rst_n),
		.valid_i(ks_valid),
		.block_i(ks_block),
		.seed_i(ks_seed),
		.left_i(ks_left),
		.total_i(ks_total),
		.prev_i(key), // carried so a stalled pass can be redone
		.first_i(ks_first),
		.valid_o(sl_valid),
		.block_o(sl_block),
		.seed_o(sl_seed),
		.left_o(sl_left),
		.total_o(sl_total),
		.prev_o(sl_prev),
		.first_o(sl_first)
	);

	match_decide u_decide (
		.clk(clk),
		.rst_n(rst_n),
		.mask_i(mask_i),
		.value_i(value_i),
		.out_full_i(out_full_i),
		.word_i(word),
		.sl_valid_i(sl_valid),
		.sl_block_i(sl_block),
		.sl_seed_i(sl_seed),
		.sl_left_i(sl_left),
		.sl_total_i(sl_total),
		.sl_prev_i(sl_prev),
		.sl_first_i(sl_first),
		.rc_valid_o(rc_valid),
		.rc_block_o(rc_block),
		.rc_seed_o(rc_seed),
		.rc_left_o(rc_left),
		.rc_total_o(rc_total),
		.rc_prev_o(rc_prev),
		.rc_first_o(rc_first),
		.result_valid_o(result_valid_o),
		.result_block_o(result_block_o),
		.result_seed_o(result_seed_o),
		.result_count_o(result_count_o),
		.result_word_o(result_word_o),
		.result_last_o(result_last_o)
	);

endmodule

// ==== design/key_schedule.sv ====
`timescale 1ns/1ns

module key_schedule (
	input logic clk,
	input logic rst_n,

	input logic valid_i,
	input logic [csa_search_pkg::BLOCK_W-1:0] block_i,
	input logic [csa_search_pkg::WORD_W-1:0] seed_i,
	input logic [csa_search_pkg::COUNT_W-1:0] left_i,
	input logic [csa_search_pkg::COUNT_W-1:0] total_i,
	input logic [csa_search_pkg::WORD_W-1:0] prev_i,
	input logic first_i,

	output logic [csa_search_pkg::WORD_W-1:0] key_o,
	output logic ks_valid_o,
	output logic [csa_search_pkg::BLOCK_W-1:0] ks_block_o,
	output logic [csa_search_pkg::WORD_W-1:0] ks_seed_o,
	output logic [csa_search_pkg::COUNT_W-1:0] ks_left_o,
	output logic [csa_search_pkg::COUNT_W-1:0] ks_total_o,
	output logic ks_first_o
);

	logic [csa_search_pkg::COUNT_W-1:0] pass_num;

	assign pass_num = total_i - left_i; // passes already done

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ks_valid_o <= 1'b0;
		end else begin
			ks_valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (first_i) begin
			key_o <= seed_i;
		end else begin
			key_o <= prev_i ^ {{(csa_search_pkg::WORD_W - csa_search_pkg::COUNT_W){1'b0}},
				pass_num};
		end
		ks_block_o <= block_i;
		ks_seed_o <= seed_i;
		ks_left_o <= left_i;
		ks_total_o <= total_i;
		ks_first_o <= first_i;
	end

endmodule

// ==== design/match_decide.sv ====
`timescale 1ns/1ns

module match_decide (
	input logic clk,
	input logic rst_n,

	input logic [csa_search_pkg::WORD_W-1:0] mask_i,
	input logic [csa_search_pkg::WORD_W-1:0] value_i,
	input logic out_full_i,
	input logic [csa_search_pkg::WORD_W-1:0] word_i,

	input logic sl_valid_i,
	input logic [csa_search_pkg::BLOCK_W-1:0] sl_block_i,
	input logic [csa_search_pkg::WORD_W-1:0] sl_seed_i,
	input logic [csa_search_pkg::COUNT_W-1:0] sl_left_i,
	input logic [csa_search_pkg::COUNT_W-1:0] sl_total_i,
	input logic [csa_search_pkg::WORD_W-1:0] sl_prev_i,
	input logic sl_first_i,

	output logic rc_valid_o,
	output logic [csa_search_pkg::BLOCK_W-1:0] rc_block_o,
	output logic [csa_search_pkg::WORD_W-1:0] rc_seed_o,
	output logic [csa_search_pkg::COUNT_W-1:0] rc_left_o,
	output logic [csa_search_pkg::COUNT_W-1:0] rc_total_o,
	output logic [csa_search_pkg::WORD_W-1:0] rc_prev_o,
	output logic rc_first_o,

	output logic result_valid_o,
	output logic [csa_search_pkg::BLOCK_W-1:0] result_block_o,
	output logic [csa_search_pkg::WORD_W-1:0] result_seed_o,
	output logic [csa_search_pkg::COUNT_W-1:0] result_count_o,
	output logic [csa_search_pkg::WORD_W-1:0] result_word_o,
	output logic result_last_o
);

	logic matched;
	logic last_pass;
	logic need_emit;
	logic stall;
	logic emit;
	logic [csa_search_pkg::COUNT_W-1:0] pass_num;

	assign matched = (mask_i != '0) && ((mask_i & value_i) == (mask_i & word_i));
	assign last_pass = (sl_left_i == csa_search_pkg::COUNT_W'(1));
	assign need_emit = sl_valid_i && (last_pass || matched);
	assign stall = need_emit && out_full_i; // consumer full, redo this pass
	assign emit = need_emit && !out_full_i;
	assign pass_num = sl_total_i - sl_left_i;

	always_comb begin
		rc_valid_o = sl_valid_i && (stall || !last_pass);
		rc_block_o = sl_block_i;
		rc_seed_o = sl_seed_i;
		rc_total_o = sl_total_i;
		if (stall) begin
			rc_left_o = sl_left_i;
			// sl_prev_i holds the key, undo the pass mix to get the old prev back
			rc_prev_o = sl_prev_i ^
				{{(csa_search_pkg::WORD_W - csa_search_pkg::COUNT_W){1'b0}}, pass_num};
			rc_first_o = sl_first_i;
		end else begin
			rc_left_o = sl_left_i - csa_search_pkg::COUNT_W'(1);
			rc_prev_o = word_i; // chain to the next key
			rc_first_o = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= emit;
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			result_block_o <= sl_block_i;
			result_seed_o <= sl_seed_i;
			result_count_o <= pass_num + csa_search_pkg::COUNT_W'(1); // 1-based pass
			result_word_o <= word_i;
			result_last_o <= last_pass;
		end
	end

	a_no_emit_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		out_full_i |=> !result_valid_o);

endmodule

// ==== design/slot_delay.sv ====
`timescale 1ns/1ns

module slot_delay #(
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic rst_n,

	input logic valid_i,
	input logic [csa_search_pkg::BLOCK_W-1:0] block_i,
	input logic [csa_search_pkg::WORD_W-1:0] seed_i,
	input logic [csa_search_pkg::COUNT_W-1:0] left_i,
	input logic [csa_search_pkg::COUNT_W-1:0] total_i,
	input logic [csa_search_pkg::WORD_W-1:0] prev_i,
	input logic first_i,

	output logic valid_o,
	output logic [csa_search_pkg::BLOCK_W-1:0] block_o,
	output logic [csa_search_pkg::WORD_W-1:0] seed_o,
	output logic [csa_search_pkg::COUNT_W-1:0] left_o,
	output logic [csa_search_pkg::COUNT_W-1:0] total_o,
	output logic [csa_search_pkg::WORD_W-1:0] prev_o,
	output logic first_o
);

	logic valid_q [DEPTH];
	logic [csa_search_pkg::BLOCK_W-1:0] block_q [DEPTH];
	logic [csa_search_pkg::WORD_W-1:0] seed_q [DEPTH];
	logic [csa_search_pkg::COUNT_W-1:0] left_q [DEPTH];
	logic [csa_search_pkg::COUNT_W-1:0] total_q [DEPTH];
	logic [csa_search_pkg::WORD_W-1:0] prev_q [DEPTH];
	logic first_q [DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= valid_i;
			for (int i = 1; i < DEPTH; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		block_q[0] <= block_i;
		seed_q[0] <= seed_i;
		left_q[0] <= left_i;
		total_q[0] <= total_i;
		prev_q[0] <= prev_i; // key of this pass
		first_q[0] <= first_i;
		for (int i = 1; i < DEPTH; i++) begin
			block_q[i] <= block_q[i-1];
			seed_q[i] <= seed_q[i-1];
			left_q[i] <= left_q[i-1];
			total_q[i] <= total_q[i-1];
			prev_q[i] <= prev_q[i-1];
			first_q[i] <= first_q[i-1];
		end
	end

	assign valid_o = valid_q[DEPTH-1];
	assign block_o = block_q[DEPTH-1];
	assign seed_o = seed_q[DEPTH-1];
	assign left_o = left_q[DEPTH-1];
	assign total_o = total_q[DEPTH-1];
	assign prev_o = prev_q[DEPTH-1];
	assign first_o = first_q[DEPTH-1];

endmodule

// ==== design/slot_entry.sv ====
`timescale 1ns/1ns

module slot_entry (
	input logic clk,
	input logic rst_n,

	input logic fifo_ready_i,
	output logic fifo_ren_o,
	input logic [csa_search_pkg::BLOCK_W-1:0] job_block_i,
	input logic [csa_search_pkg::WORD_W-1:0] job_seed_i,
	input logic [csa_search_pkg::COUNT_W-1:0] job_count_i,

	input logic rc_valid_i,
	input logic [csa_search_pkg::BLOCK_W-1:0] rc_block_i,
	input logic [csa_search_pkg::WORD_W-1:0] rc_seed_i,
	input logic [csa_search_pkg::COUNT_W-1:0] rc_left_i,
	input logic [csa_search_pkg::COUNT_W-1:0] rc_total_i,
	input logic [csa_search_pkg::WORD_W-1:0] rc_prev_i,
	input logic rc_first_i,

	output logic en_valid_o,
	output logic [csa_search_pkg::BLOCK_W-1:0] en_block_o,
	output logic [csa_search_pkg::WORD_W-1:0] en_seed_o,
	output logic [csa_search_pkg::COUNT_W-1:0] en_left_o,
	output logic [csa_search_pkg::COUNT_W-1:0] en_total_o,
	output logic [csa_search_pkg::WORD_W-1:0] en_prev_o,
	output logic en_first_o
);

	// show-ahead fifo pops its head in the same cycle
	assign fifo_ren_o = fifo_ready_i && !rc_valid_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_valid_o <= 1'b0;
		end else begin
			en_valid_o <= rc_valid_i || fifo_ready_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rc_valid_i) begin // ring slot has priority
			en_block_o <= rc_block_i;
			en_seed_o <= rc_seed_i;
			en_left_o <= rc_left_i;
			en_total_o <= rc_total_i;
			en_prev_o <= rc_prev_i;
			en_first_o <= rc_first_i;
		end else begin
			en_block_o <= job_block_i;
			en_seed_o <= job_seed_i;
			en_left_o <= job_count_i;
			en_total_o <= job_count_i;
			en_prev_o <= job_seed_i; // unused on a first pass
			en_first_o <= 1'b1;
		end
	end

	a_count_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_ren_o |-> job_count_i != '0);

	a_pop_ready: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_ren_o |-> fifo_ready_i);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the csa_search testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module csa_search_tb -f csa_search.f --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/Vcsa_search_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation passed"; then
	exit 0
fi
exit 1

// ==== test/csa_model.svh ====
`ifndef CSA_MODEL_SVH
`define CSA_MODEL_SVH

// rotate left, amount taken modulo the word width
function automatic logic [csa_search_pkg::WORD_W-1:0] model_rotl(
	input logic [csa_search_pkg::WORD_W-1:0] x,
	input int amt
);
	logic [csa_search_pkg::WORD_W-1:0] y;
	int a;

	a = amt % csa_search_pkg::WORD_W;
	y = x;
	for (int i = 0; i < a; i++) begin
		y = {y[csa_search_pkg::WORD_W-2:0], y[csa_search_pkg::WORD_W-1]};
	end
	return y;
endfunction

// all rounds of the stand-in cipher on one key
function automatic logic [csa_search_pkg::WORD_W-1:0] model_cipher(
	input logic [csa_search_pkg::WORD_W-1:0] key
);
	logic [csa_search_pkg::WORD_W-1:0] s;

	s = key;
	for (int r = 0; r < csa_search_pkg::ROUNDS; r++) begin
		s = s + model_rotl(csa_search_pkg::CIPHER_CONST, r);
		s = s ^ model_rotl(s, csa_search_pkg::ROT_MIX);
	end
	return s;
endfunction

// cipher word of pass p (0-based) of a job, keys chained from the seed
function automatic logic [csa_search_pkg::WORD_W-1:0] model_pass_word(
	input logic [csa_search_pkg::WORD_W-1:0] seed,
	input int p
);
	logic [csa_search_pkg::WORD_W-1:0] w;

	w = model_cipher(seed);
	for (int i = 1; i <= p; i++) begin
		w = model_cipher(w ^ csa_search_pkg::WORD_W'(i));
	end
	return w;
endfunction

function automatic bit model_match(
	input logic [csa_search_pkg::WORD_W-1:0] mask,
	input logic [csa_search_pkg::WORD_W-1:0] value,
	input logic [csa_search_pkg::WORD_W-1:0] word
);
	return (mask != '0) && ((mask & value) == (mask & word));
endfunction

`endif

// ==== test/csa_search_tb.sv ====
`timescale 1ns/1ns

`include "csa_model.svh"

module csa_search_tb;

	localparam int NJOBS = 17;
	localparam int MAXP = 8;
	localparam int NPHASE = 4;

	logic clk = 1'b0;
	logic rst_n;
	logic fifo_ready_i;
	logic fifo_ren_o;
	logic [csa_search_pkg::BLOCK_W-1:0] job_block_i;
	logic [csa_search_pkg::WORD_W-1:0] job_seed_i;
	logic [csa_search_pkg::COUNT_W-1:0] job_count_i;
	logic [csa_search_pkg::WORD_W-1:0] mask_i;
	logic [csa_search_pkg::WORD_W-1:0] value_i;
	logic out_full_i;
	logic result_valid_o;
	logic [csa_search_pkg::BLOCK_W-1:0] result_block_o;
	logic [csa_search_pkg::WORD_W-1:0] result_seed_o;
	logic [csa_search_pkg::COUNT_W-1:0] result_count_o;
	logic [csa_search_pkg::WORD_W-1:0] result_word_o;
	logic result_last_o;

	// job table
	logic [csa_search_pkg::BLOCK_W-1:0] t_block [NJOBS];
	logic [csa_search_pkg::WORD_W-1:0] t_seed [NJOBS];
	int t_count [NJOBS];
	int t_phase [NJOBS];
	logic [csa_search_pkg::WORD_W-1:0] t_mask [NJOBS];
	logic [csa_search_pkg::WORD_W-1:0] t_value [NJOBS];
	bit t_auto [NJOBS]; // value taken from the model word of pass 2

	// expected results per job in pass order
	logic [csa_search_pkg::WORD_W-1:0] exp_word [NJOBS][MAXP];
	int exp_cnt [NJOBS][MAXP];
	bit exp_last [NJOBS][MAXP];
	int exp_len [NJOBS];
	int got_len [NJOBS];

	int pend [$]; // job indices queued in the fifo
	int errors = 0;
	int n_results = 0;
	int done_cnt = 0;
	int cycles = 0;
	int limit = 1000000;
	int burst_left = 0;
	bit bp_en = 1'b0;

	csa_search_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.fifo_ready_i(fifo_ready_i),
		.fifo_ren_o(fifo_ren_o),
		.job_block_i(job_block_i),
		.job_seed_i(job_seed_i),
		.job_count_i(job_count_i),
		.mask_i(mask_i),
		.value_i(value_i),
		.out_full_i(out_full_i),
		.result_valid_o(result_valid_o),
		.result_block_o(result_block_o),
		.result_seed_o(result_seed_o),
		.result_count_o(result_count_o),
		.result_word_o(result_word_o),
		.result_last_o(result_last_o)
	);

	always #10 clk = ~clk;

	task automatic add_row(input int idx, input int phase, input logic [31:0] block,
		input logic [63:0] seed, input int count, input logic [63:0] mask,
		input logic [63:0] value, input bit auto_val);
		t_phase[idx] = phase;
		t_block[idx] = block;
		t_seed[idx] = seed;
		t_count[idx] = count;
		t_mask[idx] = mask;
		t_value[idx] = value;
		t_auto[idx] = auto_val;
	endtask

	task automatic build_expected(input int j);
		logic [csa_search_pkg::WORD_W-1:0] w;
		bit last;

		exp_len[j] = 0;
		got_len[j] = 0;
		for (int p = 0; p < t_count[j]; p++) begin
			w = model_pass_word(t_seed[j], p);
			last = (p == t_count[j] - 1);
			if (last || model_match(t_mask[j], t_value[j], w)) begin
				exp_word[j][exp_len[j]] = w;
				exp_cnt[j][exp_len[j]] = p + 1;
				exp_last[j][exp_len[j]] = last;
				exp_len[j]++;
			end
		end
	endtask

	function automatic int find_job(input logic [csa_search_pkg::BLOCK_W-1:0] block);
		for (int j = 0; j < NJOBS; j++) begin
			if (t_block[j] == block) return j;
		end
		return -1;
	endfunction

	// fifo and consumer drivers
	always @(posedge clk) begin
		if (rst_n) begin
			fifo_ready_i <= (pend.size() != 0) && ($urandom % 4 != 0);
			if (pend.size() != 0) begin
				job_block_i <= t_block[pend[0]];
				job_seed_i <= t_seed[pend[0]];
				job_count_i <= csa_search_pkg::COUNT_W'(t_count[pend[0]]);
			end
			if (!bp_en) begin
				out_full_i <= 1'b0;
			end else if (burst_left > 0) begin
				out_full_i <= 1'b1;
				burst_left <= burst_left - 1;
			end else begin
				out_full_i <= 1'b0;
				if ($urandom % 6 == 0) burst_left <= int'($urandom % 4) + 1;
			end
		end
	end

	// pop tracking and result checks on the falling edge
	always @(negedge clk) begin
		int j;
		int k;

		if (rst_n) begin
			assert (!fifo_ren_o || fifo_ready_i) else begin
				$display("fifo_ren_o rose without fifo_ready_i at %0t", $time);
				errors++;
			end
			assert (!fifo_ren_o || !dut0.rc_valid) else begin
				$display("job popped into an occupied slot at %0t", $time);
				errors++;
			end
			if (fifo_ren_o) begin
				if (pend.size() != 0) void'(pend.pop_front());
			end
			if (result_valid_o) begin
				n_results++;
				j = find_job(result_block_o);
				assert (j >= 0) else begin
					$display("result for unknown block %h at %0t", result_block_o, $time);
					errors++;
				end
				if (j >= 0) begin
					k = got_len[j];
					assert (k < exp_len[j]) else begin
						$display("extra result for block %h at %0t", result_block_o, $time);
						errors++;
					end
					if (k < exp_len[j]) begin
						assert (result_count_o == csa_search_pkg::COUNT_W'(exp_cnt[j][k])) else begin
							$display("FAIL %0t result_count_o got %0d exp %0d", $time,
								result_count_o, exp_cnt[j][k]);
							errors++;
						end
						assert (result_word_o == exp_word[j][k]) else begin
							$display("FAIL %0t result_word_o got %h exp %h", $time,
								result_word_o, exp_word[j][k]);
							errors++;
						end
						assert (result_last_o == exp_last[j][k]) else begin
							$display("FAIL %0t result_last_o got %0b exp %0b", $time,
								result_last_o, exp_last[j][k]);
							errors++;
						end
						assert (result_seed_o == t_seed[j]) else begin
							$display("FAIL %0t result_seed_o got %h exp %h", $time,
								result_seed_o, t_seed[j]);
							errors++;
						end
						got_len[j] = k + 1;
						if (exp_last[j][k]) done_cnt++;
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, results still missing", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int phase_jobs;
		int first_row;

		void'($urandom(32'hd6a145ec));
		rst_n = 1'b0;
		fifo_ready_i = 1'b0;
		job_block_i = '0;
		job_seed_i = '0;
		job_count_i = '0;
		mask_i = '0;
		value_i = '0;
		out_full_i = 1'b0;

		add_row(0, 1, 32'h0000_0100, 64'h0123_4567_89ab_cdef, 1, 64'h0, 64'h0, 1'b0);
		add_row(1, 2, 32'h0000_0200, 64'hfeed_face_cafe_beef, 5, 64'h0, 64'h0, 1'b0);
		add_row(2, 3, 32'h0000_0300, 64'h5a5a_1234_a5a5_4321, 6, 64'hff, 64'h0, 1'b1);
		for (int i = 3; i < NJOBS; i++) begin
			add_row(i, 4, 32'h0000_1000 + i, 64'h9e37_79b9_7f4a_7c15 * (i + 1),
				2 + (i % 5), 64'hf, 64'h5, 1'b0);
		end
		limit = 200;
		for (int j = 0; j < NJOBS; j++) begin
			if (t_auto[j]) t_value[j] = model_pass_word(t_seed[j], 2) & t_mask[j];
			build_expected(j);
			limit += t_count[j] * csa_search_pkg::RING_DEPTH * 4;
		end

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// nothing offered while the ring idles
		repeat (20) begin
			@(negedge clk);
			assert (!fifo_ren_o && !result_valid_o) else begin
				$display("ring not idle after reset at %0t", $time);
				errors++;
			end
		end

		for (int ph = 1; ph <= NPHASE; ph++) begin
			phase_jobs = 0;
			first_row = -1;
			for (int j = 0; j < NJOBS; j++) begin
				if (t_phase[j] == ph) begin
					if (first_row < 0) first_row = j;
					phase_jobs++;
				end
			end
			@(posedge clk);
			mask_i <= t_mask[first_row];
			value_i <= t_value[first_row];
			bp_en <= (ph == 4);
			done_cnt = 0;
			for (int j = 0; j < NJOBS; j++) begin
				if (t_phase[j] == ph) pend.push_back(j);
			end
			while (done_cnt < phase_jobs) @(posedge clk);
			repeat (2 * csa_search_pkg::RING_DEPTH) @(posedge clk); // catch late extras
		end

		for (int j = 0; j < NJOBS; j++) begin
			assert (got_len[j] == exp_len[j]) else begin
				$display("block %h got %0d results, expected %0d", t_block[j],
					got_len[j], exp_len[j]);
				errors++;
			end
		end

		$display("results %0d, errors %0d", n_results, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
